//--- hw/time_sync_pkg.sv
// shared widths, bit timing and frame layout; the bit period is fixed at build time, no runtime rate
`default_nettype none

package time_sync_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------

	// utc seconds, broadcast as four bytes
	typedef logic [31:0] utc_sec_t;

	// one character on the serial line
	typedef logic [7:0] tx_byte_t;

	// clk_sys cycles inside one serial bit
	typedef logic [15:0] bit_cnt_t;

	// ------------------------------------------------------------------------
	// bit timing and framing
	// ------------------------------------------------------------------------

	// clk_sys cycles per serial bit
	localparam int unsigned BIT_PERIOD = 10;

	// bytes per time frame, sent msb first
	localparam int unsigned FRAME_BYTES = 4;

	// start bit + 8 data bits + stop bit
	localparam int unsigned BITS_PER_CHAR = 10;

	// ------------------------------------------------------------------------
	// sequencer states and bundles
	// ------------------------------------------------------------------------

	typedef enum logic [3:0] {
		IDLE  = 4'h0,
		FIRE1 = 4'h1,
		WAIT1 = 4'h2,
		FIRE2 = 4'h3,
		WAIT2 = 4'h4,
		FIRE3 = 4'h5,
		WAIT3 = 4'h6,
		FIRE4 = 4'h7,
		WAIT4 = 4'h8,
		DONE  = 4'hf
	} info_state_e;

	// byte request from sequencer to serializer
	typedef struct packed {
		logic     fire;
		tx_byte_t data;
	} byte_req_t;

	// software load of the seconds counter
	typedef struct packed {
		logic     load;
		utc_sec_t value;
	} utc_set_t;

endpackage

`default_nettype wire

//--- hw/info_bit_tx.sv
// one 8n1 character per fire strobe, lsb first; fire must stay low until the cycle after done_tx
`timescale 1ns/1ps
`default_nettype none

module info_bit_tx (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  time_sync_pkg::byte_req_t byte_req,
	output logic                    done_tx,
	output logic                    tx
);

	// ------------------------------------------------------------------------
	// character state
	// ------------------------------------------------------------------------

	localparam int unsigned IDX_W = $clog2(time_sync_pkg::BITS_PER_CHAR);

	// high from the cycle after fire until the end of the stop bit
	logic active;

	// stop, data[7:0], start; bit 0 is on the line
	logic [time_sync_pkg::BITS_PER_CHAR-1:0] shreg;

	// cycles spent in the current bit
	time_sync_pkg::bit_cnt_t bit_cnt;

	// which of the ten bits is on the line
	logic [IDX_W-1:0] bit_idx;

	logic bit_end;
	logic char_end;

	assign bit_end  = (bit_cnt == time_sync_pkg::bit_cnt_t'(time_sync_pkg::BIT_PERIOD - 1));
	assign char_end = bit_end && (bit_idx == IDX_W'(time_sync_pkg::BITS_PER_CHAR - 1));

	// ------------------------------------------------------------------------
	// bit and cycle counters
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (!active) begin
			// new character starts with the start bit next cycle
			if (byte_req.fire) begin
				active  <= 1'b1;
				bit_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (bit_end) begin
			bit_cnt <= '0;
			if (char_end) begin
				active <= 1'b0;
			end else begin
				bit_idx <= bit_idx + IDX_W'(1);
			end
		end else begin
			bit_cnt <= bit_cnt + time_sync_pkg::bit_cnt_t'(1);
		end
	end

	// ------------------------------------------------------------------------
	// shift register
	// ------------------------------------------------------------------------

	// loaded on fire, shifted at each bit end
	always_ff @(posedge clk_sys) begin
		if (!active && byte_req.fire) begin
			shreg <= {1'b1, byte_req.data, 1'b0};
		end else if (active && bit_end) begin
			// fill with ones so the line stays at mark level
			shreg <= {1'b1, shreg[time_sync_pkg::BITS_PER_CHAR-1:1]};
		end
	end

	// line idles high
	assign tx = active ? shreg[0] : 1'b1;

	// last cycle of the stop bit
	assign done_tx = active && char_end;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// sequencer must wait for done_tx before the next byte
	a_no_fire_while_active : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		active |-> !byte_req.fire
	) else $error("byte fire while a character is still on the line");

endmodule

`default_nettype wire

//--- hw/utc_info_tx.sv
// utc seconds counter and msb-first frame sequencer; info strobes while busy are dropped, load beats sync
`timescale 1ns/1ps
`default_nettype none

module utc_info_tx (
	input  wire                      clk_sys,
	input  wire                      rst_n,
	input  wire                      fire_sync,
	input  wire                      fire_info,
	input  time_sync_pkg::utc_set_t  utc_set,
	input  wire                      done_tx,
	output time_sync_pkg::byte_req_t byte_req,
	output logic                     busy
);

	localparam int unsigned SEL_W = $clog2(time_sync_pkg::FRAME_BYTES);

	// ------------------------------------------------------------------------
	// seconds counter
	// ------------------------------------------------------------------------

	time_sync_pkg::utc_sec_t utc_sec;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			utc_sec <= '0;
		end else if (utc_set.load) begin
			// software value wins over a sync pulse in the same cycle
			utc_sec <= utc_set.value;
		end else if (fire_sync) begin
			utc_sec <= utc_sec + time_sync_pkg::utc_sec_t'(1);
		end
	end

	// ------------------------------------------------------------------------
	// frame sequencer
	// ------------------------------------------------------------------------

	time_sync_pkg::info_state_e state;
	time_sync_pkg::info_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			time_sync_pkg::IDLE:  if (fire_info) state_nxt = time_sync_pkg::FIRE1;
			time_sync_pkg::FIRE1: state_nxt = time_sync_pkg::WAIT1;
			time_sync_pkg::WAIT1: if (done_tx) state_nxt = time_sync_pkg::FIRE2;
			time_sync_pkg::FIRE2: state_nxt = time_sync_pkg::WAIT2;
			time_sync_pkg::WAIT2: if (done_tx) state_nxt = time_sync_pkg::FIRE3;
			time_sync_pkg::FIRE3: state_nxt = time_sync_pkg::WAIT3;
			time_sync_pkg::WAIT3: if (done_tx) state_nxt = time_sync_pkg::FIRE4;
			time_sync_pkg::FIRE4: state_nxt = time_sync_pkg::WAIT4;
			time_sync_pkg::WAIT4: if (done_tx) state_nxt = time_sync_pkg::DONE;
			time_sync_pkg::DONE:  state_nxt = time_sync_pkg::IDLE;
			default:              state_nxt = time_sync_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= time_sync_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign busy = (state != time_sync_pkg::IDLE);

	// ------------------------------------------------------------------------
	// snapshot and byte select
	// ------------------------------------------------------------------------

	// frozen at frame start so sync pulses cannot split a frame
	time_sync_pkg::utc_sec_t snapshot;

	always_ff @(posedge clk_sys) begin
		if (state == time_sync_pkg::IDLE && fire_info) begin
			snapshot <= utc_sec;
		end
	end

	logic             fire_nxt;
	logic [SEL_W-1:0] byte_idx;
	time_sync_pkg::tx_byte_t byte_sel;

	// byte_idx 0 is the most significant byte
	always_comb begin
		fire_nxt = 1'b1;
		byte_idx = '0;
		case (state)
			time_sync_pkg::FIRE1: byte_idx = SEL_W'(0);
			time_sync_pkg::FIRE2: byte_idx = SEL_W'(1);
			time_sync_pkg::FIRE3: byte_idx = SEL_W'(2);
			time_sync_pkg::FIRE4: byte_idx = SEL_W'(3);
			default:              fire_nxt = 1'b0;
		endcase
	end

	assign byte_sel = time_sync_pkg::tx_byte_t'(snapshot >>
		($bits(time_sync_pkg::tx_byte_t) *
		(time_sync_pkg::FRAME_BYTES - 1 - int'(byte_idx))));

	logic                    fire_q;
	time_sync_pkg::tx_byte_t data_q;

	// fire is a one-cycle strobe after each FIREn state
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fire_q <= 1'b0;
		end else begin
			fire_q <= fire_nxt;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fire_nxt) begin
			data_q <= byte_sel;
		end
	end

	assign byte_req = '{fire: fire_q, data: data_q};

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	a_state_legal : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		state inside {time_sync_pkg::IDLE,  time_sync_pkg::FIRE1, time_sync_pkg::WAIT1,
		              time_sync_pkg::FIRE2, time_sync_pkg::WAIT2, time_sync_pkg::FIRE3,
		              time_sync_pkg::WAIT3, time_sync_pkg::FIRE4, time_sync_pkg::WAIT4,
		              time_sync_pkg::DONE}
	) else $error("sequencer in an undefined state");

endmodule

`default_nettype wire

//--- hw/time_sync_tx.sv
// time-of-day broadcaster top; plain strobes only, info strobes during a frame are ignored
`timescale 1ns/1ps
`default_nettype none

module time_sync_tx (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire                     fire_sync,
	input  wire                     fire_info,
	input  time_sync_pkg::utc_set_t utc_set,
	output logic                    tx_info,
	output logic                    busy
);

	// ------------------------------------------------------------------------
	// sequencer to serializer
	// ------------------------------------------------------------------------

	time_sync_pkg::byte_req_t byte_req;
	logic                     done_tx;

	// counter, snapshot and byte order
	utc_info_tx utc_info_tx_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fire_sync (fire_sync),
		.fire_info (fire_info),
		.utc_set   (utc_set),
		.done_tx   (done_tx),
		.byte_req  (byte_req),
		.busy      (busy)
	);

	// serial line driver
	info_bit_tx info_bit_tx_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.byte_req (byte_req),
		.done_tx  (done_tx),
		.tx       (tx_info)
	);

endmodule

`default_nettype wire

//--- testbench/tb_time_sync_tx.sv
// decodes tx_info by line edges at mid-bit; assumes BIT_PERIOD is even enough for a 100 ns clock
`timescale 1ns/1ps
`default_nettype none

module tb_time_sync_tx;

	localparam int CLK_NS = 100;
	localparam int BIT_NS = time_sync_pkg::BIT_PERIOD * CLK_NS;
	localparam int FRAME_CYCLES = time_sync_pkg::FRAME_BYTES *
		(time_sync_pkg::BITS_PER_CHAR * time_sync_pkg::BIT_PERIOD + 2) + 3;
	// about a dozen frames plus stimulus gaps
	localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 3000;

	logic clk_sys;
	logic rst_n;
	logic fire_sync;
	logic fire_info;
	time_sync_pkg::utc_set_t utc_set;
	logic tx_info;
	logic busy;

	// reference model state
	time_sync_pkg::utc_sec_t ref_sec;
	time_sync_pkg::utc_sec_t exp_q[$];
	logic frame_open;
	int frames_rx;
	int cycle_cnt;
	string test_name;

	time_sync_tx time_sync_tx_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fire_sync (fire_sync),
		.fire_info (fire_info),
		.utc_set   (utc_set),
		.tx_info   (tx_info),
		.busy      (busy)
	);

	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	// ------------------------------------------------------------------------
	// reporting and reference
	// ------------------------------------------------------------------------

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("ERR %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	// first byte on the line carries bits 31..24, so the word reads in line order
	function automatic time_sync_pkg::utc_sec_t expected_frame(
		input time_sync_pkg::utc_sec_t sec);
		time_sync_pkg::utc_sec_t word;
		int k;
		word = '0;
		for (k = 0; k < time_sync_pkg::FRAME_BYTES; k++) begin
			word = {word[23:0], sec[31 - 8 * k -: 8]};
		end
		return word;
	endfunction

	// ------------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------------

	task automatic pulse_sync();
		@(posedge clk_sys);
		#1;
		fire_sync = 1'b1;
		ref_sec = ref_sec + 1;
		@(posedge clk_sys);
		#1;
		fire_sync = 1'b0;
	endtask

	// load wins over a sync pulse in the same cycle
	task automatic load_counter(input time_sync_pkg::utc_sec_t value, input logic with_sync);
		@(posedge clk_sys);
		#1;
		utc_set = '{load: 1'b1, value: value};
		fire_sync = with_sync;
		ref_sec = value;
		@(posedge clk_sys);
		#1;
		utc_set = '0;
		fire_sync = 1'b0;
	endtask

	task automatic send_info();
		@(posedge clk_sys);
		#1;
		check_value({test_name, "_busy"}, 32'(frame_open), 32'(busy));
		if (!frame_open) begin
			exp_q.push_back(expected_frame(ref_sec));
			frame_open = 1'b1;
		end
		fire_info = 1'b1;
		@(posedge clk_sys);
		#1;
		fire_info = 1'b0;
	endtask

	task automatic wait_frame(input int target);
		int waited;
		waited = 0;
		while (frames_rx < target) @(posedge clk_sys);
		while (busy && waited < 2 * time_sync_pkg::BIT_PERIOD) begin
			@(posedge clk_sys);
			waited++;
		end
		if (busy) begin
			report_failure($sformatf("%s: busy stayed high after the last stop bit", test_name));
		end else begin
			frame_open = 1'b0;
		end
	endtask

	// ------------------------------------------------------------------------
	// line decoder and compare
	// ------------------------------------------------------------------------

	initial begin : line_decoder
		time_sync_pkg::tx_byte_t rx_byte;
		time_sync_pkg::utc_sec_t rx_word;
		int b;
		int i;
		wait (rst_n === 1'b1);
		forever begin
			rx_word = '0;
			for (b = 0; b < time_sync_pkg::FRAME_BYTES; b++) begin
				@(negedge tx_info);
				#(BIT_NS / 2);
				if (tx_info !== 1'b0) begin
					report_failure($sformatf("%s: start bit of byte %0d did not stay low",
						test_name, b));
				end
				for (i = 0; i < 8; i++) begin
					#(BIT_NS);
					rx_byte[i] = tx_info;
				end
				#(BIT_NS);
				if (tx_info !== 1'b1) begin
					report_failure($sformatf("%s: stop bit of byte %0d is not high",
						test_name, b));
				end
				rx_word = {rx_word[23:0], rx_byte};
			end
			if (exp_q.size() == 0) begin
				report_failure($sformatf("%s: a frame was sent without an accepted request",
					test_name));
			end
			check_value(test_name, exp_q.pop_front(), rx_word);
			frames_rx++;
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout after %0d cycles, an expected frame never arrived",
				cycle_cnt));
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin : stimulus
		int n;
		time_sync_pkg::utc_sec_t v;
		clk_sys = 1'b0;
		rst_n = 1'b0;
		fire_sync = 1'b0;
		fire_info = 1'b0;
		utc_set = '0;
		ref_sec = '0;
		frame_open = 1'b0;
		frames_rx = 0;
		test_name = "reset";
		void'($urandom(74212));
		repeat (4) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		check_value("reset_tx_idle", 32'd1, 32'(tx_info));
		check_value("reset_busy", 32'd0, 32'(busy));
		send_info();
		wait_frame(1);

		test_name = "sync_count";
		n = int'($urandom_range(1, 20));
		repeat (n) pulse_sync();
		send_info();
		wait_frame(2);

		test_name = "load_plus_3";
		v = $urandom;
		load_counter(v, 1'b0);
		repeat (3) pulse_sync();
		send_info();
		wait_frame(3);

		test_name = "load_with_sync";
		v = $urandom;
		load_counter(v, 1'b1);
		send_info();
		wait_frame(4);

		// syncs during a frame land in the next one
		test_name = "sync_in_frame";
		send_info();
		repeat (5) pulse_sync();
		wait_frame(5);
		test_name = "sync_after_frame";
		send_info();
		wait_frame(6);

		test_name = "info_while_busy";
		send_info();
		repeat (20) @(posedge clk_sys);
		send_info();
		wait_frame(7);
		repeat (2 * time_sync_pkg::BITS_PER_CHAR * time_sync_pkg::BIT_PERIOD) begin
			@(posedge clk_sys);
			if (tx_info !== 1'b1) begin
				report_failure("line left idle after the frame with no request pending");
			end
		end
		check_value("no_extra_frame", 32'd7, 32'(frames_rx));

		if (exp_q.size() != 0) begin
			report_failure($sformatf("%0d requested frames never arrived", exp_q.size()));
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- time_sync_tx.f
hw/time_sync_pkg.sv
hw/info_bit_tx.sv
hw/utc_info_tx.sv
hw/time_sync_tx.sv
testbench/tb_time_sync_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the time_sync_tx testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	-f time_sync_tx.f \
	--top-module tb_time_sync_tx \
	-Mdir obj_dir \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
else
	echo "pass message not found"
	exit 1
fi
